/* hdl/cmd_regfile.sv */
// --------------------
// Control registers: RO and RW banks,
// command reads and masked writes,
// uptime and inactivity notice
// --------------------
`timescale 1ns/1ps

module cmd_regfile
    import fifo_net_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  rx_word_t  i_cmd,
    input  logic      i_cmd_valid,
    input  logic      i_tx_valid,
    input  logic      i_tx_ready,
    input  logic      i_rsp_almost_full,
    output src_word_t o_rsp,
    output logic      o_rsp_wr
);

    tick_t                    uptime;              // Free-running since reset
    tick_t                    inact_base;          // Uptime at last output activity
    tick_t                    inact_limit;
    reg_val_t [RO_WORDS-1:0]  ro_bank;
    reg_val_t [RW_WORDS-1:0]  rw_bank;

    reg_addr_t   cmd_addr;
    reg_val_t    cmd_mask;
    reg_val_t    cmd_value;
    reg_val_t    rd_value;
    logic [13:0] word_idx;                         // Even-aligned byte offset / 2
    logic        cmd_rw_bank;
    logic        cmd_read;
    logic        cmd_write;
    logic        inact_en;
    logic        inact_fire;

    // --------------------
    // Read-only bank
    // --------------------
    assign ro_bank[0]   = RO_MAGIC;                         // +0
    assign ro_bank[1]   = {VERSION_MAJOR, VERSION_MINOR};   // +2
    assign ro_bank[2]   = {8'h00, DEVICE_ID};               // +4
    assign ro_bank[3]   = '0;                               // +6 pad
    assign ro_bank[7:4] = uptime;                           // +8 uptime, low word first

    // --------------------
    // Command decode
    // --------------------
    assign cmd_addr    = i_cmd.addr;
    assign cmd_mask    = i_cmd.payload[15:0];
    assign cmd_value   = i_cmd.payload[31:16];
    assign cmd_rw_bank = cmd_addr[15];
    assign word_idx    = cmd_addr[14:1];
    assign cmd_read    = i_cmd_valid & i_cmd.cmd_read;
    // RO bank ignores writes, as do offsets past the end
    assign cmd_write   = i_cmd_valid & i_cmd.cmd_write & cmd_rw_bank
                         & (word_idx < 14'(RW_WORDS));

    // Bank value at offset, zero past the bank end
    always_comb
    begin
        rd_value = '0;
        if (cmd_rw_bank)
        begin
            if (word_idx < 14'(RW_WORDS))
                rd_value = rw_bank[word_idx[RW_IDX_W-1:0]];
        end
        else if (word_idx < 14'(RO_WORDS))
            rd_value = ro_bank[word_idx[RO_IDX_W-1:0]];
    end

    // --------------------
    // Inactivity
    // --------------------
    assign inact_en    = rw_bank[RW_CTRL_INACT_EN / 16][RW_CTRL_INACT_EN % 16];
    assign inact_limit = inact_base + tick_t'(rw_bank[RW_TICKS_WORD +: 2]);

    // Notice yields to any command and to a nearly full queue
    assign inact_fire = inact_en & ~cmd_read & ~cmd_write & ~i_rsp_almost_full
                        & (uptime > inact_limit);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            uptime     <= '0;
            inact_base <= '0;
            o_rsp_wr   <= 1'b0;
            rw_bank    <= '0;
            rw_bank[0] <= RW_MAGIC;
        end
        else
        begin
            uptime   <= uptime + 1'b1;
            o_rsp_wr <= cmd_read | inact_fire;

            if (inact_fire)
                rw_bank[RW_CTRL_INACT_EN / 16][RW_CTRL_INACT_EN % 16] <= 1'b0; // One-shot

            // Masked update, mask 1 takes the new bit
            if (cmd_write)
            begin
                rw_bank[word_idx[RW_IDX_W-1:0]] <=
                    (rw_bank[word_idx[RW_IDX_W-1:0]] & ~cmd_mask) | (cmd_value & cmd_mask);
            end

            // Host busy or stalled restarts the idle window
            if ((i_tx_valid & i_tx_ready) | ~i_tx_ready)
                inact_base <= uptime;
        end
    end

    // Response payload, enters the queue next edge
    always_ff @(posedge clk)
    begin
        if (cmd_read)
        begin
            o_rsp.data <= {cmd_addr, rd_value};        // Address echo, value
            o_rsp.ctx  <= 2'b00;
        end
        else if (inact_fire)
        begin
            o_rsp.data <= INACT_NOTICE;
            o_rsp.ctx  <= 2'b00;
        end
    end

endmodule

/* hdl/fifo_net_pkg.sv */
// --------------------
// Host and queue word structs, magic values,
// register bank layout and queue sizing
// --------------------
package fifo_net_pkg;

    // --------------------
    // Host word
    // --------------------
    typedef enum logic [1:0] {
        TYPE_TLP  = 2'd0,
        TYPE_CFG  = 2'd1,
        TYPE_LOOP = 2'd2,
        TYPE_CMD  = 2'd3
    } rx_type_e;

    typedef struct packed {
        logic [31:0] payload;                       // Cmd: value hi, mask lo
        logic [15:0] addr;                          // Bit 15 picks RW bank
        logic [1:0]  reserved;
        logic        cmd_write;
        logic        cmd_read;
        logic [1:0]  ctx;                           // Bit 0 is TLP last
        rx_type_e    rx_type;
        logic [7:0]  magic;
    } rx_word_t;

    localparam logic [7:0] RX_MAGIC = 8'h77;

    // Queue entry, output word, TLP out
    typedef struct packed {
        logic [1:0]  ctx;
        logic [31:0] data;
    } src_word_t;

    typedef struct packed {
        logic [1:0]  ctx;
        logic [1:0]  tag;
        logic [31:0] data;
    } tx_word_t;

    typedef struct packed {
        logic        last;
        logic [31:0] data;
    } tlp_out_t;

    typedef logic [15:0] reg_addr_t;
    typedef logic [15:0] reg_val_t;
    typedef logic [63:0] tick_t;

    // --------------------
    // Sources and queues
    // --------------------
    localparam int NUM_SRC   = 4;
    localparam int SRC_IDX_W = $clog2(NUM_SRC);
    localparam int SRC_TLP   = 0;                   // Index is priority, 0 first
    localparam int SRC_CFG   = 1;
    localparam int SRC_LOOP  = 2;
    localparam int SRC_CMD   = 3;
    localparam logic [NUM_SRC-1:0][1:0] SRC_TAG = {2'b11, 2'b10, 2'b01, 2'b00};

    localparam int QUEUE_DEPTH = 16;
    localparam int QUEUE_AFULL = 12;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    // --------------------
    // Register banks
    // --------------------
    localparam reg_val_t   RO_MAGIC      = 16'hab89;
    localparam reg_val_t   RW_MAGIC      = 16'hefcd;
    localparam logic [7:0] VERSION_MAJOR = 8'h04;
    localparam logic [7:0] VERSION_MINOR = 8'h11;
    localparam logic [7:0] DEVICE_ID     = 8'h03;

    localparam int RO_BYTES = 16;                   // Magic, version, id, pad, uptime
    localparam int RW_BYTES = 8;                    // Magic, control, ticks
    localparam int RO_WORDS = RO_BYTES / 2;
    localparam int RW_WORDS = RW_BYTES / 2;
    localparam int RO_IDX_W = $clog2(RO_WORDS);
    localparam int RW_IDX_W = $clog2(RW_WORDS);

    localparam int RW_CTRL_INACT_EN = 16;           // Bit 0 of offset 2
    localparam int RW_TICKS_WORD    = 2;            // 32-bit ticks at offset 4

    localparam logic [31:0] INACT_NOTICE = 32'hffffcede;

endpackage

/* hdl/fifo_net_top.sv */
// --------------------
// Packet network top: router, transmit
// queues, priority mux, control registers
// --------------------
`timescale 1ns/1ps

module fifo_net_top
    import fifo_net_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  rx_word_t  i_rx,
    input  logic      i_rx_valid,
    input  src_word_t i_tlp_tx,
    input  logic      i_tlp_tx_valid,
    input  src_word_t i_cfg_tx,
    input  logic      i_cfg_tx_valid,
    input  logic      i_tx_ready,
    output tlp_out_t  o_tlp,
    output logic      o_tlp_valid,
    output rx_word_t  o_cfg,
    output logic      o_cfg_valid,
    output logic      o_tlp_tx_ready,
    output logic      o_cfg_tx_ready,
    output tx_word_t  o_tx,
    output logic      o_tx_valid
);

    // Per-queue wires, indexed by source
    logic      [NUM_SRC-1:0] q_wr;
    logic      [NUM_SRC-1:0] q_rd;
    logic      [NUM_SRC-1:0] q_full;
    logic      [NUM_SRC-1:0] q_afull;
    logic      [NUM_SRC-1:0] q_valid;
    src_word_t [NUM_SRC-1:0] q_din;
    src_word_t [NUM_SRC-1:0] q_dout;

    src_word_t loop_word;
    logic      loop_wr;
    rx_word_t  cmd_word;
    logic      cmd_valid;
    src_word_t rsp_word;
    logic      rsp_wr;

    rx_router i_rx_router (
        .clk         (clk),
        .rst         (rst),
        .i_rx        (i_rx),
        .i_rx_valid  (i_rx_valid),
        .o_tlp       (o_tlp),
        .o_tlp_valid (o_tlp_valid),
        .o_cfg       (o_cfg),
        .o_cfg_valid (o_cfg_valid),
        .o_loop      (loop_word),
        .o_loop_wr   (loop_wr),
        .o_cmd       (cmd_word),
        .o_cmd_valid (cmd_valid)
    );

    // --------------------
    // Queue feeds
    // --------------------
    assign o_tlp_tx_ready  = ~q_full[SRC_TLP];
    assign o_cfg_tx_ready  = ~q_full[SRC_CFG];
    assign q_wr[SRC_TLP]   = i_tlp_tx_valid & o_tlp_tx_ready;
    assign q_wr[SRC_CFG]   = i_cfg_tx_valid & o_cfg_tx_ready;
    assign q_wr[SRC_LOOP]  = loop_wr;               // No back-pressure toward host
    assign q_wr[SRC_CMD]   = rsp_wr;
    assign q_din[SRC_TLP]  = i_tlp_tx;
    assign q_din[SRC_CFG]  = i_cfg_tx;
    assign q_din[SRC_LOOP] = loop_word;
    assign q_din[SRC_CMD]  = rsp_word;

    for (genvar g = 0; g < NUM_SRC; g++)
    begin : g_queue
        tx_queue i_tx_queue (
            .clk           (clk),
            .rst           (rst),
            .i_wr          (q_wr[g]),
            .i_din         (q_din[g]),
            .i_rd          (q_rd[g]),
            .o_full        (q_full[g]),
            .o_almost_full (q_afull[g]),
            .o_valid       (q_valid[g]),
            .o_dout        (q_dout[g])
        );
    end

    tx_mux i_tx_mux (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (q_valid),
        .i_dout     (q_dout),
        .i_tx_ready (i_tx_ready),
        .o_rd       (q_rd),
        .o_tx       (o_tx),
        .o_tx_valid (o_tx_valid)
    );

    cmd_regfile i_cmd_regfile (
        .clk               (clk),
        .rst               (rst),
        .i_cmd             (cmd_word),
        .i_cmd_valid       (cmd_valid),
        .i_tx_valid        (o_tx_valid),
        .i_tx_ready        (i_tx_ready),
        .i_rsp_almost_full (q_afull[SRC_CMD]),
        .o_rsp             (rsp_word),
        .o_rsp_wr          (rsp_wr)
    );

endmodule

/* hdl/rx_router.sv */
// --------------------
// Receive router: magic check, type decode,
// one registered output per destination
// --------------------
`timescale 1ns/1ps

module rx_router
    import fifo_net_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  rx_word_t  i_rx,
    input  logic      i_rx_valid,
    output tlp_out_t  o_tlp,
    output logic      o_tlp_valid,
    output rx_word_t  o_cfg,
    output logic      o_cfg_valid,
    output src_word_t o_loop,
    output logic      o_loop_wr,
    output rx_word_t  o_cmd,
    output logic      o_cmd_valid
);

    rx_word_t rx_q;                                 // Last accepted host word
    logic     rx_ok;

    // Bad magic drops the word
    assign rx_ok = i_rx_valid & (i_rx.magic == RX_MAGIC);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            o_tlp_valid <= 1'b0;
            o_cfg_valid <= 1'b0;
            o_loop_wr   <= 1'b0;
            o_cmd_valid <= 1'b0;
        end
        else
        begin
            // At most one destination per word
            o_tlp_valid <= rx_ok & (i_rx.rx_type == TYPE_TLP);
            o_cfg_valid <= rx_ok & (i_rx.rx_type == TYPE_CFG);
            o_loop_wr   <= rx_ok & (i_rx.rx_type == TYPE_LOOP);
            o_cmd_valid <= rx_ok & (i_rx.rx_type == TYPE_CMD);
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_rx_valid)
            rx_q <= i_rx;
    end

    // Destination views of the held word
    assign o_tlp.data  = rx_q.payload;
    assign o_tlp.last  = rx_q.ctx[0];
    assign o_cfg       = rx_q;
    assign o_loop.data = rx_q.payload;
    assign o_loop.ctx  = rx_q.ctx;
    assign o_cmd       = rx_q;

endmodule

/* hdl/tx_mux.sv */
// --------------------
// Fixed-priority drain of the queues into
// tagged host words, valid/ready output
// --------------------
`timescale 1ns/1ps

module tx_mux
    import fifo_net_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic      [NUM_SRC-1:0]   i_valid,
    input  src_word_t [NUM_SRC-1:0]   i_dout,
    input  logic                      i_tx_ready,
    output logic      [NUM_SRC-1:0]   o_rd,
    output tx_word_t                  o_tx,
    output logic                      o_tx_valid
);

    logic [SRC_IDX_W-1:0] sel;                      // Winning queue
    logic                 any;
    logic                 load;

    // Output reg empty or draining this cycle
    assign load = ~o_tx_valid | i_tx_ready;

    // Lowest index wins, so scan high to low
    always_comb
    begin
        sel = '0;
        any = 1'b0;
        for (int i = NUM_SRC - 1; i >= 0; i--)
        begin
            if (i_valid[i])
            begin
                sel = SRC_IDX_W'(i);
                any = 1'b1;
            end
        end
    end

    // Pop only when the head is taken
    always_comb
    begin
        o_rd = '0;
        if (load & any)
            o_rd[sel] = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            o_tx_valid <= 1'b0;
        else if (load)
            o_tx_valid <= any;                      // Held while stalled
    end

    always_ff @(posedge clk)
    begin
        if (load & any)
        begin
            o_tx.data <= i_dout[sel].data;
            o_tx.ctx  <= i_dout[sel].ctx;
            o_tx.tag  <= SRC_TAG[sel];
        end
    end

endmodule

/* hdl/tx_queue.sv */
// --------------------
// Transmit queue, synchronous FIFO with
// first-word-fall-through head
// --------------------
`timescale 1ns/1ps

module tx_queue
    import fifo_net_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      i_wr,
    input  src_word_t i_din,
    input  logic      i_rd,
    output logic      o_full,
    output logic      o_almost_full,
    output logic      o_valid,
    output src_word_t o_dout
);

    src_word_t              mem [QUEUE_DEPTH];      // Payload store
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_CNT_W-1:0] count;
    logic                   wr_en;
    logic                   rd_en;

    assign wr_en = i_wr & ~o_full;                  // Full queue drops the write
    assign rd_en = i_rd & o_valid;

    assign o_full        = (count == QUEUE_CNT_W'(QUEUE_DEPTH));
    assign o_almost_full = (count >= QUEUE_CNT_W'(QUEUE_AFULL));
    assign o_valid       = (count != '0);
    assign o_dout        = mem[rd_ptr];             // Head falls through

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= i_din;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= (wr_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= (rd_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // Count holds when both happen
            if (wr_en & ~rd_en)
                count <= count + 1'b1;
            else if (rd_en & ~wr_en)
                count <= count - 1'b1;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the packet network testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module tb_fifo_net -o tb_fifo_net || { echo "build failed"; exit 1; }

out="$(./obj_dir/tb_fifo_net 2>&1)"
echo "$out"
echo "$out" | grep -qF "*** TEST PASSED ***" && exit 0 || exit 1

/* sim.f */
hdl/fifo_net_pkg.sv
hdl/rx_router.sv
hdl/tx_queue.sv
hdl/tx_mux.sv
hdl/cmd_regfile.sv
hdl/fifo_net_top.sv
tests/fifo_net_asserts.sv
tests/tb_fifo_net.sv

/* tests/fifo_net_asserts.sv */
// --------------------
// Bound checks: output handshake,
// receive exclusivity, reset state
// --------------------
`timescale 1ns/1ps

module fifo_net_asserts
    import fifo_net_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input tx_word_t i_tx,
    input logic     i_tx_valid,
    input logic     i_tx_ready,
    input logic     i_tlp_valid,
    input logic     i_cfg_valid
);

    // Stalled word holds until taken
    a_tx_stable: assert property (@(posedge clk) disable iff (rst)
        (i_tx_valid && !i_tx_ready) |=> (i_tx_valid && $stable(i_tx)))
        else $error("o_tx changed while valid and not ready");

    a_rx_excl: assert property (@(posedge clk) disable iff (rst)
        !(i_tlp_valid && i_cfg_valid))              // One destination per word
        else $error("o_tlp_valid and o_cfg_valid high together");

    // Sync reset, outputs quiet one edge later
    a_rst_quiet: assert property (@(posedge clk)
        rst |=> !(i_tx_valid || i_tlp_valid || i_cfg_valid))
        else $error("output valid high during reset");

endmodule

bind fifo_net_top fifo_net_asserts i_fifo_net_asserts (
    .clk         (clk),
    .rst         (rst),
    .i_tx        (o_tx),
    .i_tx_valid  (o_tx_valid),
    .i_tx_ready  (i_tx_ready),
    .i_tlp_valid (o_tlp_valid),
    .i_cfg_valid (o_cfg_valid)
);

/* tests/tb_fifo_net.sv */
// --------------------
// Testbench for the packet network: routing, loopback,
// register access, priority drain, inactivity notice
// --------------------
`timescale 1ns/1ps

module tb_fifo_net
    import fifo_net_pkg::*;
();

    localparam int RST_CYCLES  = 8;
    localparam int LOOP_WORDS  = 24;
    localparam int PRIO_WORDS  = 4;
    localparam int INACT_TICKS = 20;
    localparam int NUM_CMDS    = 15;
    // Cycle budget summed per test, plus margin
    localparam int WATCHDOG_CYCLES = RST_CYCLES + 60 + LOOP_WORDS * 16 + NUM_CMDS * 10
                                     + PRIO_WORDS * 3 * 8 + INACT_TICKS * 8 + 200;
    localparam int READY_HIGH = 0;
    localparam int READY_LOW  = 1;
    localparam int READY_RAND = 2;

    logic      clk = 1'b0;
    logic      rst;
    rx_word_t  i_rx;
    logic      i_rx_valid;
    src_word_t i_tlp_tx;
    logic      i_tlp_tx_valid;
    src_word_t i_cfg_tx;
    logic      i_cfg_tx_valid;
    logic      i_tx_ready;
    tlp_out_t  o_tlp;
    logic      o_tlp_valid;
    rx_word_t  o_cfg;
    logic      o_cfg_valid;
    logic      o_tlp_tx_ready;
    logic      o_cfg_tx_ready;
    tx_word_t  o_tx;
    logic      o_tx_valid;

    tlp_out_t  exp_tlp[$];                          // Expected per output, in order
    rx_word_t  exp_cfg[$];
    tx_word_t  exp_tx[$];
    reg_val_t  rw_model [RW_WORDS];                 // RW bank as the host sees it
    integer    data_seed  = 3;
    integer    ready_seed = 3;
    integer    ready_rnd;
    integer    rnd;
    int        ready_mode;
    int        checks = 0;
    int        errors = 0;
    int        test_err_base = 0;
    src_word_t sw;
    tlp_out_t  tw;
    rx_word_t  rw;

    always #4 clk = ~clk;

    fifo_net_top i_fifo_net_top (.*);

    // --------------------
    // Helpers
    // --------------------
    function automatic rx_word_t make_rx(input logic [7:0] magic, input rx_type_e t,
                                         input logic [1:0] ctx, input logic rd,
                                         input logic wr, input reg_addr_t addr,
                                         input logic [31:0] payload);
        rx_word_t w;
        w           = '0;
        w.magic     = magic;
        w.rx_type   = t;
        w.ctx       = ctx;
        w.cmd_read  = rd;
        w.cmd_write = wr;
        w.addr      = addr;
        w.payload   = payload;
        return w;
    endfunction

    // Register value a read should return
    function automatic reg_val_t model_value(input reg_addr_t addr);
        int       idx;
        reg_val_t v;
        idx = int'(addr[14:1]);
        v   = '0;
        if (addr[15])
        begin
            if (idx < RW_WORDS)
                v = rw_model[idx];
        end
        else if (idx == 0)
            v = RO_MAGIC;
        else if (idx == 1)
            v = {VERSION_MAJOR, VERSION_MINOR};
        else if (idx == 2)
            v = {8'h00, DEVICE_ID};
        return v;                                   // Pad and past-end read 0
    endfunction

    // Expected host word for a queued source word
    function automatic tx_word_t tb_expect_tx(input src_word_t w, input int src);
        tx_word_t t;
        t.data = w.data;
        t.ctx  = w.ctx;
        case (src)
            SRC_TLP: t.tag = 2'b00;
            SRC_CFG: t.tag = 2'b01;
            SRC_LOOP: t.tag = 2'b10;
            default: t.tag = 2'b11;                 // Command responses
        endcase
        return t;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_fail(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic send_rx(input rx_word_t w);
        @(posedge clk);
        i_rx       <= w;
        i_rx_valid <= 1'b1;
        @(posedge clk);
        i_rx_valid <= 1'b0;
    endtask

    // External TLP or CFG source, valid/ready
    task automatic send_src(input int src, input src_word_t w);
        logic ready;
        @(posedge clk);
        if (src == SRC_TLP)
        begin
            i_tlp_tx       <= w;
            i_tlp_tx_valid <= 1'b1;
        end
        else
        begin
            i_cfg_tx       <= w;
            i_cfg_tx_valid <= 1'b1;
        end
        @(posedge clk);
        ready = (src == SRC_TLP) ? o_tlp_tx_ready : o_cfg_tx_ready;
        i_tlp_tx_valid <= 1'b0;
        i_cfg_tx_valid <= 1'b0;
        if (ready)
            exp_tx.push_back(tb_expect_tx(w, src));
        else
            report_fail("transmit queue was not ready for a source word");
    endtask

    task automatic read_reg(input reg_addr_t addr);
        src_word_t r;
        r.data = {addr, model_value(addr)};         // Address echo, value
        r.ctx  = 2'b00;
        exp_tx.push_back(tb_expect_tx(r, SRC_CMD));
        send_rx(make_rx(RX_MAGIC, TYPE_CMD, 2'b00, 1'b1, 1'b0, addr, 32'h0));
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_val_t value,
                             input reg_val_t mask);
        int       idx;
        reg_val_t v;
        idx = int'(addr[14:1]);
        if (addr[15] && idx < RW_WORDS)
        begin
            v = rw_model[idx];
            for (int b = 0; b < 16; b++)
            begin
                if (mask[b])
                    v[b] = value[b];                // Only masked bits change
            end
            rw_model[idx] = v;
        end
        send_rx(make_rx(RX_MAGIC, TYPE_CMD, 2'b00, 1'b0, 1'b1, addr, {value, mask}));
    endtask

    task automatic wait_drain();
        while (exp_tx.size() != 0 || exp_tlp.size() != 0 || exp_cfg.size() != 0)
            @(posedge clk);
    endtask

    task automatic finish_test(input string name);
        $display("%s finished, %0d errors", name, errors - test_err_base);
        test_err_base = errors;
    endtask

    // --------------------
    // Ready driver and compare
    // --------------------
    always @(posedge clk)
    begin
        ready_rnd = $random(ready_seed);
        if (ready_mode == READY_RAND)
            i_tx_ready <= ready_rnd[0];
        else
            i_tx_ready <= (ready_mode == READY_HIGH);
    end

    always @(posedge clk)
    begin
        if (!rst)
        begin
            if (o_tlp_valid && exp_tlp.size() == 0)
                report_fail("word appeared on o_tlp when none was expected");
            else if (o_tlp_valid)
                check_val("o_tlp", 64'(o_tlp), 64'(exp_tlp.pop_front()));
            if (o_cfg_valid && exp_cfg.size() == 0)
                report_fail("word appeared on o_cfg when none was expected");
            else if (o_cfg_valid)
                check_val("o_cfg", 64'(o_cfg), 64'(exp_cfg.pop_front()));
            if (o_tx_valid && i_tx_ready && exp_tx.size() == 0)
                report_fail("word transferred on o_tx when none was expected");
            else if (o_tx_valid && i_tx_ready)
                check_val("o_tx", 64'(o_tx), 64'(exp_tx.pop_front()));
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, run exceeded %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // --------------------
    // Test sequence
    // --------------------
    initial
    begin
        rst            = 1'b1;
        i_rx           = '0;
        i_rx_valid     = 1'b0;
        i_tlp_tx       = '0;
        i_tlp_tx_valid = 1'b0;
        i_cfg_tx       = '0;
        i_cfg_tx_valid = 1'b0;
        i_tx_ready     = 1'b1;
        ready_mode     = READY_HIGH;
        rw_model[0]    = RW_MAGIC;                  // Control and ticks start at zero
        for (int i = 1; i < RW_WORDS; i++)
            rw_model[i] = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // Routing, good words then bad magic
        tw.data = 32'hdeadbeef;
        tw.last = 1'b1;
        exp_tlp.push_back(tw);
        send_rx(make_rx(RX_MAGIC, TYPE_TLP, 2'b01, 1'b0, 1'b0, 16'h0, 32'hdeadbeef));
        tw.data = 32'h01234567;
        tw.last = 1'b0;
        exp_tlp.push_back(tw);
        send_rx(make_rx(RX_MAGIC, TYPE_TLP, 2'b10, 1'b0, 1'b0, 16'h0, 32'h01234567));
        rw = make_rx(RX_MAGIC, TYPE_CFG, 2'b11, 1'b0, 1'b0, 16'h1234, 32'ha5a55a5a);
        exp_cfg.push_back(rw);
        send_rx(rw);
        send_rx(make_rx(8'h76, TYPE_TLP, 2'b01, 1'b0, 1'b0, 16'h0, 32'h11111111));
        send_rx(make_rx(8'h76, TYPE_CFG, 2'b00, 1'b0, 1'b0, 16'h0, 32'h22222222));
        send_rx(make_rx(8'h76, TYPE_LOOP, 2'b00, 1'b0, 1'b0, 16'h0, 32'h33333333));
        send_rx(make_rx(8'h76, TYPE_CMD, 2'b00, 1'b1, 1'b0, 16'h0, 32'h0));
        wait_drain();
        repeat (8) @(posedge clk);                  // Window for dropped words to leak
        finish_test("routing");

        // Loopback under random ready
        ready_mode = READY_RAND;
        for (int i = 0; i < LOOP_WORDS; i++)
        begin
            while (exp_tx.size() >= 8)              // Keeps loop queue clear of full
                @(posedge clk);
            rnd     = $random(data_seed);
            sw.data = rnd;
            rnd     = $random(data_seed);
            sw.ctx  = rnd[1:0];
            exp_tx.push_back(tb_expect_tx(sw, SRC_LOOP));
            send_rx(make_rx(RX_MAGIC, TYPE_LOOP, sw.ctx, 1'b0, 1'b0, 16'h0, sw.data));
        end
        wait_drain();
        ready_mode = READY_HIGH;
        finish_test("loopback");

        // RO reads, last one past the bank
        read_reg(16'h0000);
        read_reg(16'h0002);
        read_reg(16'h0004);
        read_reg(16'h0010);
        wait_drain();
        finish_test("register reads");

        // Masked RW write, ignored RO write
        write_reg(16'h8004, 16'hffff, 16'hffff);
        write_reg(16'h8004, 16'h1234, 16'h0ff0);
        read_reg(16'h8004);
        write_reg(16'h0000, 16'h5555, 16'hffff);
        read_reg(16'h0000);
        read_reg(16'h8000);                         // RW magic at same offset untouched
        wait_drain();
        finish_test("masked writes");

        // Priority, load everything while stalled
        ready_mode = READY_LOW;
        repeat (2) @(posedge clk);
        for (int i = 0; i < PRIO_WORDS; i++)
        begin
            sw.data = 32'h10000000 + i;
            sw.ctx  = 2'(i);
            send_src(SRC_TLP, sw);
        end
        for (int i = 0; i < PRIO_WORDS; i++)
        begin
            sw.data = 32'h20000000 + i;
            sw.ctx  = 2'(i);
            send_src(SRC_CFG, sw);
        end
        for (int i = 0; i < PRIO_WORDS; i++)
        begin
            sw.data = 32'h30000000 + i;
            sw.ctx  = 2'(i);
            exp_tx.push_back(tb_expect_tx(sw, SRC_LOOP));
            send_rx(make_rx(RX_MAGIC, TYPE_LOOP, sw.ctx, 1'b0, 1'b0, 16'h0, sw.data));
        end
        repeat (4) @(posedge clk);                  // Router plus queue latency
        ready_mode = READY_HIGH;
        wait_drain();
        finish_test("priority");

        // Inactivity notice, one shot
        write_reg(16'h8004, 16'(INACT_TICKS), 16'hffff);
        write_reg(16'h8006, 16'h0000, 16'hffff);
        sw.data = INACT_NOTICE;
        sw.ctx  = 2'b00;
        exp_tx.push_back(tb_expect_tx(sw, SRC_CMD));
        write_reg(16'h8002, 16'h0001, 16'h0001);
        wait_drain();
        repeat (INACT_TICKS * 3) @(posedge clk);   // A second notice would show here
        rw_model[RW_CTRL_INACT_EN / 16][RW_CTRL_INACT_EN % 16] = 1'b0;
        read_reg(16'h8002);
        wait_drain();
        finish_test("inactivity");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
